//--- Bender.yml
package:
  name: cb_write

sources:
  - rtl/slam_cfg_pkg.sv
  - rtl/cb_ctrl_pkg.sv
  - rtl/cb_cmd_seq.sv
  - rtl/cb_dinb_map.sv
  - rtl/cb_bank.sv
  - rtl/cb_write_top.sv
  - target: simulation
    files:
      - dv/cb_seq_properties.sv
      - dv/cb_write_tb.sv

//--- dv/cb_seq_properties.sv
`default_nettype none

module cb_seq_properties (
  input logic       clk,
  input logic       sys_rst,
  input logic       cmd_req,
  input logic       cmd_ack,
  input logic       wr_en,
  input logic [1:0] state
);

  localparam logic [1:0] ST_IDLE = 2'd0;  // Sequencer FSM encoding.
  localparam logic [1:0] ST_ACK  = 2'd3;

  int err_cnt = 0;  // Number of assertion failures.

  ack_needs_req: assert property (@(posedge clk) disable iff (sys_rst)
    $rose(cmd_ack) |-> $past(cmd_req))
    else begin
      $error("cmd_ack rose without a pending request");
      err_cnt++;
    end

  ack_drops: assert property (@(posedge clk) disable iff (sys_rst)
    (cmd_ack && !cmd_req) |=> !cmd_ack)
    else begin
      $error("cmd_ack stayed high after cmd_req dropped");
      err_cnt++;
    end

  no_write_idle: assert property (@(posedge clk) disable iff (sys_rst)
    (state == ST_IDLE || state == ST_ACK) |-> !wr_en)
    else begin
      $error("wr_en high while the sequencer is idle or acknowledging");
      err_cnt++;
    end

endmodule

bind cb_cmd_seq cb_seq_properties cb_seq_properties_i (
  .clk     (clk),
  .sys_rst (sys_rst),
  .cmd_req (cmd_req),
  .cmd_ack (cmd_ack),
  .wr_en   (wr_en),
  .state   (state)
);

`default_nettype wire

//--- dv/cb_write_tb.sv
`default_nettype none

module cb_write_tb;

  localparam int RSA_DW     = 32;
  localparam int ROWS       = 64;
  localparam int LANES      = slam_cfg_pkg::LANES;
  localparam int MAX_CYCLES = 2000;  // The tests need about 300 cycles.

  typedef logic [LANES-1:0][RSA_DW-1:0] row_t;

  logic                                clk;
  logic                                sys_rst;
  logic                                cmd_req;
  cb_ctrl_pkg::cb_cmd_t                cmd;
  logic                                cmd_ack;
  logic signed [LANES-1:0][RSA_DW-1:0] c_row;
  slam_cfg_pkg::pose_t                 pose;
  slam_cfg_pkg::lm_t                   lm;
  logic [cb_ctrl_pkg::ROW_AW-1:0]      rd_addr;
  logic signed [LANES-1:0][RSA_DW-1:0] rd_data;

  row_t        shadow [ROWS];  // Expected bank contents.
  bit          touched [ROWS];
  logic [31:0] lcg_state;
  int          pass_cnt;
  int          fail_cnt;
  int          cycles;

  cb_write_top #(.RSA_DW(RSA_DW), .ROWS(ROWS)) cb_write_top_i (
    .clk     (clk),
    .sys_rst (sys_rst),
    .cmd_req (cmd_req),
    .cmd     (cmd),
    .cmd_ack (cmd_ack),
    .c_row   (c_row),
    .pose    (pose),
    .lm      (lm),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Test failed");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int rows_for(logic [1:0] op);
    case (op)
      cb_ctrl_pkg::OP_POSE: return 3;
      cb_ctrl_pkg::OP_LM:   return 2;
      default:              return 1;
    endcase
  endfunction

  // Row that step k of command c should leave in the bank.
  function automatic row_t expect_row(cb_ctrl_pkg::cb_cmd_t c, int k);
    row_t r;
    int   half;
    r    = '0;
    half = c.l_k_0 ? 0 : 2;
    if (c.op == cb_ctrl_pkg::OP_C && c.dir == cb_ctrl_pkg::DIR_POS) begin
      r = c_row;
    end else if (c.op == cb_ctrl_pkg::OP_C && c.dir == cb_ctrl_pkg::DIR_NEG) begin
      for (int i = 0; i < LANES; i++) r[i] = c_row[LANES-1-i];
    end else if (c.op == cb_ctrl_pkg::OP_C && c.dir == cb_ctrl_pkg::DIR_NEW) begin
      r[half]     = c_row[0];
      r[half + 1] = c_row[1];
    end else if (c.op == cb_ctrl_pkg::OP_POSE) begin
      r[k-1] = (k == 1) ? pose.x_hat : (k == 2) ? pose.y_hat : pose.xita_hat;
    end else if (c.op == cb_ctrl_pkg::OP_LM) begin
      r[half + k - 1] = (k == 1) ? lm.lkx_hat : lm.lky_hat;
    end
    return r;
  endfunction

  task automatic check(input bit ok, input string msg);
    assert (ok) pass_cnt++;
    else begin
      $display("FAIL %0t: %s", $time, msg);
      fail_cnt++;
    end
  endtask

  task automatic new_inputs();
    for (int i = 0; i < LANES; i++) c_row[i] = lcg_next();
    pose = '{x_hat: lcg_next(), y_hat: lcg_next(), xita_hat: lcg_next()};
    lm   = '{lkx_hat: lcg_next(), lky_hat: lcg_next()};
  endtask

  // Full four-phase handshake; ack is checked to stay high for hold cycles.
  task automatic do_cmd(input logic [1:0] op, input logic [1:0] dir, input logic l_k_0,
                        input int base, input int hold);
    cb_ctrl_pkg::cb_cmd_t           c;
    int                             n;
    int                             lat;
    logic [cb_ctrl_pkg::ROW_AW-1:0] addr;
    c = '{op: op, dir: dir, l_k_0: l_k_0, base_row: cb_ctrl_pkg::ROW_AW'(base)};
    n = rows_for(op);
    for (int k = 1; k <= n; k++) begin
      addr          = cb_ctrl_pkg::ROW_AW'(base + k - 1);
      shadow[addr]  = expect_row(c, k);
      touched[addr] = 1'b1;
    end
    cmd     = c;
    cmd_req = 1'b1;
    lat     = 0;
    while (!cmd_ack) begin
      @(posedge clk);
      #2;
      lat++;
    end
    check(lat == n + 2, $sformatf("op %0d ack latency %0d, expected %0d", op, lat, n + 2));
    repeat (hold) begin
      @(posedge clk);
      #2;
      check(cmd_ack, "cmd_ack dropped while cmd_req was held");
    end
    cmd_req = 1'b0;
    @(posedge clk);
    #2;
    check(!cmd_ack, "cmd_ack still high one cycle after cmd_req dropped");
  endtask

  task automatic read_row(input int addr, output row_t data);
    rd_addr = cb_ctrl_pkg::ROW_AW'(addr);
    @(posedge clk);
    #2;
    data = rd_data;
  endtask

  task automatic check_row(input int addr);
    row_t got;
    read_row(addr, got);
    check(got == shadow[addr], $sformatf("row %0d read %h, expected %h",
                                         addr, got, shadow[addr]));
  endtask

  task automatic end_test(input string name, input int fails_before);
    $display("%-14s finished, %0d errors", name, fail_cnt - fails_before);
  endtask

  task automatic test_handshake();
    int f;
    f = fail_cnt;
    check(!cmd_ack, "cmd_ack high after reset");
    new_inputs();
    do_cmd(cb_ctrl_pkg::OP_C, cb_ctrl_pkg::DIR_POS, 1'b1, 0, 3);
    do_cmd(cb_ctrl_pkg::OP_POSE, cb_ctrl_pkg::DIR_IDLE, 1'b0, 8, 2);
    do_cmd(cb_ctrl_pkg::OP_LM, cb_ctrl_pkg::DIR_IDLE, 1'b1, 16, 1);
    end_test("handshake", f);
  endtask

  task automatic test_c_copy();
    int f;
    f = fail_cnt;
    new_inputs();
    do_cmd(cb_ctrl_pkg::OP_C, cb_ctrl_pkg::DIR_POS, 1'b0, 20, 0);
    check_row(20);
    new_inputs();
    do_cmd(cb_ctrl_pkg::OP_C, cb_ctrl_pkg::DIR_NEG, 1'b0, 21, 0);
    check_row(21);
    do_cmd(cb_ctrl_pkg::OP_C, cb_ctrl_pkg::DIR_IDLE, 1'b0, 20, 0);  // Zeros over row 20.
    check_row(20);
    end_test("c_copy", f);
  endtask

  task automatic test_new_lm();
    int f;
    f = fail_cnt;
    new_inputs();
    do_cmd(cb_ctrl_pkg::OP_C, cb_ctrl_pkg::DIR_NEW, 1'b1, 24, 0);
    do_cmd(cb_ctrl_pkg::OP_C, cb_ctrl_pkg::DIR_NEW, 1'b0, 25, 0);
    check_row(24);
    check_row(25);
    end_test("new_landmark", f);
  endtask

  task automatic test_pose();
    int f;
    f = fail_cnt;
    new_inputs();
    do_cmd(cb_ctrl_pkg::OP_C, cb_ctrl_pkg::DIR_POS, 1'b0, 33, 0);  // Guard row.
    new_inputs();
    do_cmd(cb_ctrl_pkg::OP_POSE, cb_ctrl_pkg::DIR_IDLE, 1'b0, 30, 0);
    for (int r = 30; r <= 33; r++) check_row(r);
    end_test("pose", f);
  endtask

  task automatic test_lm();
    int f;
    f = fail_cnt;
    new_inputs();
    do_cmd(cb_ctrl_pkg::OP_LM, cb_ctrl_pkg::DIR_IDLE, 1'b1, 40, 0);
    new_inputs();
    do_cmd(cb_ctrl_pkg::OP_LM, cb_ctrl_pkg::DIR_IDLE, 1'b0, 42, 0);
    for (int r = 40; r <= 43; r++) check_row(r);
    end_test("landmark", f);
  endtask

  task automatic test_back_to_back();
    int          f;
    logic [31:0] r;
    f = fail_cnt;
    for (int n = 0; n < 10; n++) begin
      r = lcg_next();
      new_inputs();
      do_cmd(2'(r[15:8] % 3), r[17:16], r[20], int'(r[29:24]), 0);
    end
    for (int a = 0; a < ROWS; a++) begin
      if (touched[a]) check_row(a);
    end
    end_test("back_to_back", f);
  endtask

  initial begin
    clk       = 1'b0;
    sys_rst   = 1'b1;
    cmd_req   = 1'b0;
    cmd       = '0;
    c_row     = '0;
    pose      = '0;
    lm        = '0;
    rd_addr   = '0;
    lcg_state = 32'd8;
    pass_cnt  = 0;
    fail_cnt  = 0;
    cycles    = 0;
    repeat (10) @(posedge clk);
    #2;
    sys_rst = 1'b0;
    test_handshake();
    test_c_copy();
    test_new_lm();
    test_pose();
    test_lm();
    test_back_to_back();
    $display("Checks passed: %0d, checks failed: %0d, assertion failures: %0d",
             pass_cnt, fail_cnt, cb_write_top_i.cb_cmd_seq_i.cb_seq_properties_i.err_cnt);
    if (fail_cnt == 0 && cb_write_top_i.cb_cmd_seq_i.cb_seq_properties_i.err_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- rtl/cb_bank.sv
`default_nettype none

module cb_bank #(
  parameter int RSA_DW = slam_cfg_pkg::DEF_RSA_DW,
  parameter int ROWS   = 64
) (
  input  logic                                               clk,
  input  logic                                               wr_en,
  input  logic [cb_ctrl_pkg::ROW_AW-1:0]                     wr_addr,
  input  logic signed [slam_cfg_pkg::LANES-1:0][RSA_DW-1:0]  dinb,
  input  logic [cb_ctrl_pkg::ROW_AW-1:0]                     rd_addr,
  output logic signed [slam_cfg_pkg::LANES-1:0][RSA_DW-1:0]  rd_data
);

  // One entry holds a full row of lanes.
  logic [slam_cfg_pkg::LANES-1:0][RSA_DW-1:0] mem [ROWS];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= dinb;
    end
  end

  // Read before write on an address collision.
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

//--- rtl/cb_cmd_seq.sv
`default_nettype none

module cb_cmd_seq (
  input  logic                                clk,
  input  logic                                sys_rst,
  input  logic                                cmd_req,
  input  cb_ctrl_pkg::cb_cmd_t                cmd,
  output logic                                cmd_ack,
  output cb_ctrl_pkg::cb_sel_t                sel,
  output logic [cb_ctrl_pkg::SEQ_CNT_DW-1:0]  seq_cnt,
  output logic                                l_k_0,
  output logic                                wr_en,
  output logic [cb_ctrl_pkg::ROW_AW-1:0]      wr_addr
);

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    WAIT_WB,
    ACK
  } state_t;

  state_t state;

  logic [cb_ctrl_pkg::SEQ_CNT_DW-1:0] last_step;   // Row count of the latched command.
  logic                               step_vld;    // A select is being presented to the mapper.
  logic [cb_ctrl_pkg::ROW_AW-1:0]     step_addr;   // Row address of the current step.
  cb_ctrl_pkg::cb_sel_t               sel_acc;
  logic [cb_ctrl_pkg::SEQ_CNT_DW-1:0] rows_acc;
  logic                               accept;

  assign accept = (state == IDLE) && cmd_req;

  // Decode the incoming opcode into a source group and a row count.
  always_comb begin
    sel_acc.grp = cb_ctrl_pkg::SEL_GRP_IDLE;
    sel_acc.dir = cb_ctrl_pkg::DIR_IDLE;
    rows_acc    = 2'd1;
    case (cmd.op)
      cb_ctrl_pkg::OP_C: begin
        sel_acc.grp = cb_ctrl_pkg::SEL_GRP_C;
        sel_acc.dir = cmd.dir;  // Only C rows carry a direction.
      end
      cb_ctrl_pkg::OP_POSE: begin
        sel_acc.grp = cb_ctrl_pkg::SEL_GRP_POSE;
        rows_acc    = 2'd3;
      end
      cb_ctrl_pkg::OP_LM: begin
        sel_acc.grp = cb_ctrl_pkg::SEL_GRP_LM;
        rows_acc    = 2'd2;
      end
      default: begin
        // Unknown opcodes write a single zero row.
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      state    <= IDLE;
      sel      <= '{grp: cb_ctrl_pkg::SEL_GRP_IDLE, dir: cb_ctrl_pkg::DIR_IDLE};
      seq_cnt  <= '0;
      l_k_0    <= 1'b0;
      step_vld <= 1'b0;
      cmd_ack  <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (cmd_req) begin
            state    <= RUN;
            sel      <= sel_acc;
            seq_cnt  <= 2'd1;
            l_k_0    <= cmd.l_k_0;
            step_vld <= 1'b1;
          end
        end
        RUN: begin
          if (seq_cnt == last_step) begin
            state    <= WAIT_WB;
            sel      <= '{grp: cb_ctrl_pkg::SEL_GRP_IDLE, dir: cb_ctrl_pkg::DIR_IDLE};
            seq_cnt  <= '0;
            step_vld <= 1'b0;
          end else begin
            seq_cnt <= seq_cnt + 1'b1;
          end
        end
        WAIT_WB: begin
          state   <= ACK;  // The last row is written at this edge.
          cmd_ack <= 1'b1;
        end
        ACK: begin
          if (!cmd_req) begin
            state   <= IDLE;
            cmd_ack <= 1'b0;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      last_step <= rows_acc;
      step_addr <= cmd.base_row;
    end else if (state == RUN) begin
      step_addr <= step_addr + 1'b1;
    end
    wr_addr <= step_addr;  // Lines up with the mapper's output register.
  end

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      wr_en <= 1'b0;
    end else begin
      wr_en <= step_vld;
    end
  end

endmodule

`default_nettype wire

//--- rtl/cb_ctrl_pkg.sv
`default_nettype none

package cb_ctrl_pkg;

  localparam int ROW_AW     = 6;  // Row address width of the covariance block.
  localparam int SEQ_CNT_DW = 2;  // Step counter width.

  // Source groups for the write row.
  localparam logic [2:0] SEL_GRP_IDLE = 3'b000;
  localparam logic [2:0] SEL_GRP_C    = 3'b001;
  localparam logic [2:0] SEL_GRP_POSE = 3'b101;
  localparam logic [2:0] SEL_GRP_LM   = 3'b110;

  // Copy directions for C rows.
  localparam logic [1:0] DIR_IDLE = 2'b00;
  localparam logic [1:0] DIR_POS  = 2'b01;
  localparam logic [1:0] DIR_NEG  = 2'b10;
  localparam logic [1:0] DIR_NEW  = 2'b11;

  // Command opcodes.
  localparam logic [1:0] OP_C    = 2'd0;  // One C row.
  localparam logic [1:0] OP_POSE = 2'd1;  // Three pose rows.
  localparam logic [1:0] OP_LM   = 2'd2;  // Two landmark rows.

  typedef struct packed {
    logic [2:0] grp;
    logic [1:0] dir;
  } cb_sel_t;

  typedef struct packed {
    logic [1:0]        op;
    logic [1:0]        dir;
    logic              l_k_0;
    logic [ROW_AW-1:0] base_row;
  } cb_cmd_t;

endpackage

`default_nettype wire

//--- rtl/cb_dinb_map.sv
`default_nettype none

module cb_dinb_map #(
  parameter int RSA_DW = slam_cfg_pkg::DEF_RSA_DW
) (
  input  logic                                                 clk,
  input  logic                                                 sys_rst,
  input  cb_ctrl_pkg::cb_sel_t                                 sel,
  input  logic                                                 l_k_0,
  input  logic [cb_ctrl_pkg::SEQ_CNT_DW-1:0]                   seq_cnt,
  input  slam_cfg_pkg::pose_t                                  pose,
  input  slam_cfg_pkg::lm_t                                    lm,
  input  logic signed [slam_cfg_pkg::LANES-1:0][RSA_DW-1:0]    c_row,
  output logic signed [slam_cfg_pkg::LANES-1:0][RSA_DW-1:0]    dinb
);

  logic signed [slam_cfg_pkg::LANES-1:0][RSA_DW-1:0] row_d;
  logic signed [RSA_DW-1:0] x_w;
  logic signed [RSA_DW-1:0] y_w;
  logic signed [RSA_DW-1:0] xita_w;
  logic signed [RSA_DW-1:0] lkx_w;
  logic signed [RSA_DW-1:0] lky_w;

  // Estimates are held at the default width and cut down to RSA_DW.
  assign x_w    = RSA_DW'(pose.x_hat);
  assign y_w    = RSA_DW'(pose.y_hat);
  assign xita_w = RSA_DW'(pose.xita_hat);
  assign lkx_w  = RSA_DW'(lm.lkx_hat);
  assign lky_w  = RSA_DW'(lm.lky_hat);

  always_comb begin
    row_d = '0;
    case (sel.grp)
      cb_ctrl_pkg::SEL_GRP_C: begin
        case (sel.dir)
          cb_ctrl_pkg::DIR_POS: begin
            row_d = c_row;
          end
          cb_ctrl_pkg::DIR_NEG: begin
            for (int i = 0; i < slam_cfg_pkg::LANES; i++) begin
              row_d[i] = c_row[slam_cfg_pkg::LANES-1-i];  // Lane-reversed copy.
            end
          end
          cb_ctrl_pkg::DIR_NEW: begin
            if (l_k_0) begin
              row_d[0] = c_row[0];
              row_d[1] = c_row[1];
            end else begin
              row_d[2] = c_row[0];  // New landmark sits in the upper half.
              row_d[3] = c_row[1];
            end
          end
          default: begin
            row_d = '0;
          end
        endcase
      end
      cb_ctrl_pkg::SEL_GRP_POSE: begin
        case (seq_cnt)
          2'd1: row_d[0] = x_w;
          2'd2: row_d[1] = y_w;
          2'd3: row_d[2] = xita_w;
          default: row_d = '0;
        endcase
      end
      cb_ctrl_pkg::SEL_GRP_LM: begin
        case (seq_cnt)
          2'd1: begin
            if (l_k_0) begin
              row_d[0] = lkx_w;
            end else begin
              row_d[2] = lkx_w;
            end
          end
          2'd2: begin
            if (l_k_0) begin
              row_d[1] = lky_w;
            end else begin
              row_d[3] = lky_w;
            end
          end
          default: row_d = '0;
        endcase
      end
      default: begin
        row_d = '0;  // Idle and unknown groups give a zero row.
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      dinb <= '0;
    end else begin
      dinb <= row_d;
    end
  end

endmodule

`default_nettype wire

//--- rtl/cb_write_top.sv
`default_nettype none

module cb_write_top #(
  parameter int RSA_DW = slam_cfg_pkg::DEF_RSA_DW,
  parameter int ROWS   = 64
) (
  input  logic                                               clk,
  input  logic                                               sys_rst,
  input  logic                                               cmd_req,
  input  cb_ctrl_pkg::cb_cmd_t                               cmd,
  output logic                                               cmd_ack,
  input  logic signed [slam_cfg_pkg::LANES-1:0][RSA_DW-1:0]  c_row,
  input  slam_cfg_pkg::pose_t                                pose,
  input  slam_cfg_pkg::lm_t                                  lm,
  input  logic [cb_ctrl_pkg::ROW_AW-1:0]                     rd_addr,
  output logic signed [slam_cfg_pkg::LANES-1:0][RSA_DW-1:0]  rd_data
);

  cb_ctrl_pkg::cb_sel_t                              sel;
  logic [cb_ctrl_pkg::SEQ_CNT_DW-1:0]                seq_cnt;
  logic                                              l_k_0;
  logic                                              wr_en;
  logic [cb_ctrl_pkg::ROW_AW-1:0]                    wr_addr;
  logic signed [slam_cfg_pkg::LANES-1:0][RSA_DW-1:0] dinb;

  cb_cmd_seq cb_cmd_seq_i (
    .clk     (clk),
    .sys_rst (sys_rst),
    .cmd_req (cmd_req),
    .cmd     (cmd),
    .cmd_ack (cmd_ack),
    .sel     (sel),
    .seq_cnt (seq_cnt),
    .l_k_0   (l_k_0),
    .wr_en   (wr_en),
    .wr_addr (wr_addr)
  );

  cb_dinb_map #(
    .RSA_DW (RSA_DW)
  ) cb_dinb_map_i (
    .clk     (clk),
    .sys_rst (sys_rst),
    .sel     (sel),
    .l_k_0   (l_k_0),
    .seq_cnt (seq_cnt),
    .pose    (pose),
    .lm      (lm),
    .c_row   (c_row),
    .dinb    (dinb)
  );

  cb_bank #(
    .RSA_DW (RSA_DW),
    .ROWS   (ROWS)
  ) cb_bank_i (
    .clk     (clk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .dinb    (dinb),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

endmodule

`default_nettype wire

//--- rtl/slam_cfg_pkg.sv
`default_nettype none

package slam_cfg_pkg;

  localparam int LANES      = 4;   // Words per covariance row.
  localparam int DEF_RSA_DW = 32;  // Default word width of the estimator state.

  // Robot pose estimate.
  typedef struct packed {
    logic signed [DEF_RSA_DW-1:0] x_hat;
    logic signed [DEF_RSA_DW-1:0] y_hat;
    logic signed [DEF_RSA_DW-1:0] xita_hat;
  } pose_t;

  // Landmark position estimate.
  typedef struct packed {
    logic signed [DEF_RSA_DW-1:0] lkx_hat;
    logic signed [DEF_RSA_DW-1:0] lky_hat;
  } lm_t;

endpackage

`default_nettype wire

//--- src.f
rtl/slam_cfg_pkg.sv
rtl/cb_ctrl_pkg.sv
rtl/cb_cmd_seq.sv
rtl/cb_dinb_map.sv
rtl/cb_bank.sv
rtl/cb_write_top.sv
dv/cb_seq_properties.sv
dv/cb_write_tb.sv
